//--- test/hdrPatterns.txt
// columns: bright midHigh midLow dark (rrggbb hex), strobes vs hs de (binary), fused pixel
// all-black and all-white exposures get weight 1
000000 000000 000000 000000 110 000000
ffffff ffffff ffffff ffffff 001 ffffff
808080 808080 808080 808080 011 808080
123456 123456 123456 123456 111 123456
a0b0c0 a0b0c0 a0b0c0 a0b0c0 101 a0b0c0
ff0000 ff0000 ff0000 ff0000 100 ff0000
0a0b0c 0a0b0c 0a0b0c 0a0b0c 010 0a0b0c
ffffff 808080 404040 000000 001 6a6a6a
ffffff ffffff 808080 000000 011 808080
c8c8c8 969696 646464 323232 111 7e7e7e
ff8040 c06020 804010 402008 001 b85c24
ffffff ffffff ffffff 000000 000 bfbfbf
000000 000000 000000 ff00ff 101 fa00fa
00ff00 0000ff ff0000 000000 011 545454
102030 405060 708090 a0b0c0 001 667686
fefefe 010101 7f7f7f 808080 110 7f7f7f
ffffff ff8080 402020 100808 111 b05959

//--- filelist.f
common/hdrPkg.sv
weight/exposureWeight.sv
src/pixelAlign.sv
fusion/fusionDivider.sv
fusion/weightedFusion.sv
src/hdrFusionTop.sv
test/hdrFusionTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --assert -Wno-fatal -j 0
TOP       = hdrFusionTb
FILELIST  = filelist.f
BUILD     = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(BUILD)

//--- test/hdrFusionTb.sv
`timescale 1ns/1ps

module hdrFusionTb;

	localparam int clkPeriod = 100;
	localparam int resetCycles = 5;
	localparam int randCount = 240;
	localparam hdrPkg::syncStrobes_t idleStrobes = 3'b110;   // vs and hs high while de is low

	logic clk;
	logic reset;
	hdrPkg::exposureSet_t exposures;
	hdrPkg::syncStrobes_t syncIn;
	hdrPkg::pixel_t fusedPixel;
	hdrPkg::syncStrobes_t syncOut;

	hdrPkg::exposureSet_t patExp [$];    // vectors from the pattern file
	hdrPkg::syncStrobes_t patSync [$];
	hdrPkg::pixel_t patFused [$];
	hdrPkg::pixel_t expPixQ [$];         // one entry per driven cycle
	hdrPkg::syncStrobes_t expSyncQ [$];
	hdrPkg::pixel_t wantPix;
	hdrPkg::syncStrobes_t wantSync;
	logic [31:0] lfsrState;
	logic patternsLoaded = 1'b0;
	int checks = 0;
	int mismatches = 0;
	int otherErrors = 0;

	hdrFusionTop DUT
	(
		.clk        (clk),
		.reset      (reset),
		.exposures  (exposures),
		.syncIn     (syncIn),
		.fusedPixel (fusedPixel),
		.syncOut    (syncOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// ====================
	// reference model
	// ====================
	function automatic logic [7:0] lumaOf(hdrPkg::pixel_t p);
		int sum;
		int prod;
		sum = int'(p.r) + int'(p.g) + int'(p.b);
		prod = sum * 341;   // one third in 1/1024 units
		return 8'((prod >> 10) + ((prod >> 9) & 1));
	endfunction

	function automatic logic [7:0] weightOf(logic [7:0] luma);
		int li;
		int lo;
		li = int'(luma);
		lo = (li < 255 - li) ? li : 255 - li;
		return 8'(2 * lo + 1);
	endfunction

	function automatic hdrPkg::pixel_t fuseModel(hdrPkg::exposureSet_t e);
		hdrPkg::pixel_t px [4];
		int w;
		int wSum;
		int numR;
		int numG;
		int numB;
		hdrPkg::pixel_t res;
		px[0] = e.bright;
		px[1] = e.midHigh;
		px[2] = e.midLow;
		px[3] = e.dark;
		wSum = 0;
		numR = 0;
		numG = 0;
		numB = 0;
		for (int k = 0; k < 4; k++)
		begin
			w = int'(weightOf(lumaOf(px[k])));
			wSum += w;
			numR += w * int'(px[k].r);
			numG += w * int'(px[k].g);
			numB += w * int'(px[k].b);
		end
		res.r = 8'(numR / wSum);   // floor of the weighted average
		res.g = 8'(numG / wSum);
		res.b = 8'(numB / wSum);
		return res;
	endfunction

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic nextBit();
		lfsrState = {lfsrState[30:0], lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
		return lfsrState[0];
	endfunction

	function automatic hdrPkg::pixel_t randomPixel();
		logic [23:0] v;
		v = '0;
		for (int k = 0; k < 24; k++)
			v = {v[22:0], nextBit()};
		return v;
	endfunction

	function automatic hdrPkg::syncStrobes_t randomStrobes();
		logic [2:0] v;
		v = '0;
		for (int k = 0; k < 3; k++)
			v = {v[1:0], nextBit()};
		return v;
	endfunction

	task automatic driveCycle(input hdrPkg::exposureSet_t e, input hdrPkg::syncStrobes_t s,
		input hdrPkg::pixel_t want);
		@(posedge clk);
		exposures <= e;
		syncIn <= s;
		expPixQ.push_back(want);
		expSyncQ.push_back(s);
	endtask

	// ====================
	// output checks
	// ====================
	always @(negedge clk)
	begin
		if (reset || expPixQ.size() <= hdrPkg::totalLatency)
		begin
			// reset contents still fill the pipeline
			assert (syncOut == idleStrobes) else
			begin
				mismatches++;
				$display("mismatch at %0t: syncOut expected %b, got %b", $time,
					idleStrobes, syncOut);
			end
			assert (fusedPixel == '0) else
			begin
				mismatches++;
				$display("mismatch at %0t: fusedPixel expected 000000, got %h", $time,
					fusedPixel);
			end
		end
		else
		begin
			wantPix = expPixQ.pop_front();   // driven 17 edges ago
			wantSync = expSyncQ.pop_front();
			checks++;
			assert (fusedPixel == wantPix) else
			begin
				mismatches++;
				$display("mismatch at %0t: fusedPixel expected %h, got %h", $time,
					wantPix, fusedPixel);
			end
			assert (syncOut == wantSync) else
			begin
				mismatches++;
				$display("mismatch at %0t: syncOut expected %b, got %b", $time,
					wantSync, syncOut);
			end
		end
	end

	initial
	begin
		int limitCycles;
		wait (patternsLoaded);
		limitCycles = 2 * (resetCycles + patExp.size() + randCount + hdrPkg::totalLatency);
		#(limitCycles * clkPeriod);
		$display("timeout: the pixel stream did not finish within %0d cycles", limitCycles);
		$display("Errors found");
		$finish;
	end

	// ====================
	// stimulus
	// ====================
	initial
	begin
		int fd;
		int rc;
		int n;
		string line;
		logic [23:0] pb, pm, pl, pd, pe;
		logic [2:0] ps;
		hdrPkg::exposureSet_t e;
		reset = 1'b1;
		exposures = '0;
		syncIn = idleStrobes;
		lfsrState = 32'h97ee;

		fd = $fopen("test/hdrPatterns.txt", "r");
		if (fd == 0)
		begin
			otherErrors++;
			$display("could not open the pattern file test/hdrPatterns.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				rc = $fgets(line, fd);
				if (rc > 0)
				begin
					n = $sscanf(line, "%h %h %h %h %b %h", pb, pm, pl, pd, ps, pe);
					if (n == 6)   // comment lines give no match
					begin
						patExp.push_back({pb, pm, pl, pd});
						patSync.push_back(ps);
						patFused.push_back(pe);
					end
				end
			end
			$fclose(fd);
		end
		if (patExp.size() == 0)
		begin
			otherErrors++;
			$display("the pattern file held no vectors");
		end
		patternsLoaded = 1'b1;

		for (int i = 0; i < resetCycles; i++)
		begin
			driveCycle('0, idleStrobes, '0);
			if (i == resetCycles - 1)
				reset <= 1'b0;
		end

		foreach (patExp[i])
		begin
			assert (fuseModel(patExp[i]) == patFused[i]) else
			begin
				otherErrors++;
				$display("the reference model disagrees with pattern vector %0d", i);
			end
			driveCycle(patExp[i], patSync[i], patFused[i]);
		end

		// back to back, every 16th set has four equal exposures
		for (int i = 0; i < randCount; i++)
		begin
			e.bright = randomPixel();
			e.midHigh = (i % 16 == 0) ? e.bright : randomPixel();
			e.midLow = (i % 16 == 0) ? e.bright : randomPixel();
			e.dark = (i % 16 == 0) ? e.bright : randomPixel();
			driveCycle(e, randomStrobes(), fuseModel(e));
		end

		for (int i = 0; i < hdrPkg::totalLatency; i++)
			driveCycle('0, idleStrobes, '0);
		@(posedge clk);   // last real vector checked on the negedge before

		$display("checked %0d outputs: %0d mismatches, %0d other errors", checks, mismatches,
			otherErrors);
		if (mismatches + otherErrors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- src/hdrFusionTop.sv
`timescale 1ns/1ps

module hdrFusionTop
(
	input  logic clk,
	input  logic reset,
	input  hdrPkg::exposureSet_t exposures,
	input  hdrPkg::syncStrobes_t syncIn,
	output hdrPkg::pixel_t fusedPixel,
	output hdrPkg::syncStrobes_t syncOut
);

	wire hdrPkg::weightSet_t weightSet;
	wire hdrPkg::exposureSet_t alignedExposures;
	wire hdrPkg::syncStrobes_t alignedSync;

	// ====================
	// weight path
	// ====================
	exposureWeight uBright
	(
		.clk    (clk),
		.reset  (reset),
		.pixel  (exposures.bright),
		.weight (weightSet.bright)
	);

	exposureWeight uMidHigh
	(
		.clk    (clk),
		.reset  (reset),
		.pixel  (exposures.midHigh),
		.weight (weightSet.midHigh)
	);

	exposureWeight uMidLow
	(
		.clk    (clk),
		.reset  (reset),
		.pixel  (exposures.midLow),
		.weight (weightSet.midLow)
	);

	exposureWeight uDark
	(
		.clk    (clk),
		.reset  (reset),
		.pixel  (exposures.dark),
		.weight (weightSet.dark)
	);

	// pixels and strobes wait for their weights
	pixelAlign uAlign
	(
		.clk              (clk),
		.reset            (reset),
		.exposures        (exposures),
		.syncIn           (syncIn),
		.alignedExposures (alignedExposures),
		.alignedSync      (alignedSync)
	);

	weightedFusion uFusion
	(
		.clk              (clk),
		.reset            (reset),
		.weights          (weightSet),
		.alignedExposures (alignedExposures),
		.alignedSync      (alignedSync),
		.fusedPixel       (fusedPixel),
		.syncOut          (syncOut)
	);

endmodule

//--- fusion/weightedFusion.sv
`timescale 1ns/1ps

module weightedFusion
(
	input  logic clk,
	input  logic reset,
	input  hdrPkg::weightSet_t weights,
	input  hdrPkg::exposureSet_t alignedExposures,
	input  hdrPkg::syncStrobes_t alignedSync,
	output hdrPkg::pixel_t fusedPixel,
	output hdrPkg::syncStrobes_t syncOut
);

	// [exposure][channel]: exposure 3 is bright, channel 2 is r
	logic [3:0][2:0][hdrPkg::chanWidth-1:0] chanIn;
	logic [3:0][hdrPkg::weightWidth-1:0] weightIn;

	logic [3:0][2:0][2*hdrPkg::chanWidth-1:0] prod;   // stage 1
	logic [1:0][2:0][2*hdrPkg::chanWidth:0] pairSum;  // stage 2
	logic [2:0][hdrPkg::numWidth-1:0] num;            // stage 3
	logic [3:0][hdrPkg::weightWidth-1:0] wtReg;
	logic [1:0][hdrPkg::weightWidth:0] wtPair;
	logic [hdrPkg::weightSumWidth-1:0] wtSum;
	hdrPkg::syncStrobes_t [2:0] syncDly;

	logic [hdrPkg::chanWidth-1:0] quoR;
	logic [hdrPkg::chanWidth-1:0] quoG;
	logic [hdrPkg::chanWidth-1:0] quoB;
	hdrPkg::syncStrobes_t divSync;

	assign chanIn = alignedExposures;
	assign weightIn = weights;

	// ====================
	// products and adder tree
	// ====================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			prod <= '0;
			pairSum <= '0;
			num <= '0;
			wtReg <= '0;
			wtPair <= '0;
			wtSum <= '0;
			syncDly <= {3{hdrPkg::syncIdle}};
		end
		else
		begin
			for (int c = 0; c < 3; c++)
			begin
				for (int e = 0; e < 4; e++)
					prod[e][c] <= weightIn[e] * chanIn[e][c];
				pairSum[1][c] <= prod[3][c] + prod[2][c];   // bright + midHigh
				pairSum[0][c] <= prod[1][c] + prod[0][c];   // midLow + dark
				num[c] <= pairSum[1][c] + pairSum[0][c];
			end
			// weight sum follows the same three steps
			wtReg <= weightIn;
			wtPair[1] <= wtReg[3] + wtReg[2];
			wtPair[0] <= wtReg[1] + wtReg[0];
			wtSum <= wtPair[1] + wtPair[0];
			syncDly <= {syncDly[1:0], alignedSync};
		end
	end

	// ====================
	// per-channel divide
	// ====================
	fusionDivider uDivR
	(
		.clk      (clk),
		.reset    (reset),
		.dividend (num[2]),
		.divisor  (wtSum),
		.syncIn   (syncDly[2]),
		.quotient (quoR),
		.syncOut  (divSync)
	);

	fusionDivider uDivG
	(
		.clk      (clk),
		.reset    (reset),
		.dividend (num[1]),
		.divisor  (wtSum),
		.syncIn   (syncDly[2]),
		.quotient (quoG),
		.syncOut  ()   // same as uDivR
	);

	fusionDivider uDivB
	(
		.clk      (clk),
		.reset    (reset),
		.dividend (num[0]),
		.divisor  (wtSum),
		.syncIn   (syncDly[2]),
		.quotient (quoB),
		.syncOut  ()
	);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			fusedPixel <= '0;
			syncOut <= hdrPkg::syncIdle;
		end
		else
		begin
			fusedPixel <= '{r: quoR, g: quoG, b: quoB};
			syncOut <= divSync;
		end
	end

endmodule

//--- fusion/fusionDivider.sv
`timescale 1ns/1ps

module fusionDivider
(
	input  logic clk,
	input  logic reset,
	input  logic [hdrPkg::numWidth-1:0] dividend,
	input  logic [hdrPkg::weightSumWidth-1:0] divisor,
	input  hdrPkg::syncStrobes_t syncIn,
	output logic [hdrPkg::chanWidth-1:0] quotient,
	output hdrPkg::syncStrobes_t syncOut
);

	// entry 0 is the divider input, entry k the output of stage k
	logic [hdrPkg::numWidth-1:0] remPipe [0:hdrPkg::chanWidth];
	logic [hdrPkg::weightSumWidth-1:0] divPipe [0:hdrPkg::chanWidth];
	logic [hdrPkg::chanWidth-1:0] quoPipe [0:hdrPkg::chanWidth];
	hdrPkg::syncStrobes_t syncPipe [0:hdrPkg::chanWidth];

	assign remPipe[0] = dividend;
	assign divPipe[0] = divisor;
	assign quoPipe[0] = '0;
	assign syncPipe[0] = syncIn;

	// ====================
	// restoring stages
	// ====================
	for (genvar i = 0; i < hdrPkg::chanWidth; i++)
	begin : gStage
		logic [hdrPkg::numWidth-1:0] shifted;
		logic fits;

		// divisor lined up with quotient bit (chanWidth-1-i), msb first
		assign shifted = hdrPkg::numWidth'(divPipe[i]) << (hdrPkg::chanWidth - 1 - i);
		// a zero divisor only comes from reset contents and yields zero
		assign fits = (divPipe[i] != '0) && (remPipe[i] >= shifted);

		always_ff @(posedge clk or posedge reset)
		begin
			if (reset)
			begin
				remPipe[i+1] <= '0;
				divPipe[i+1] <= '0;
				quoPipe[i+1] <= '0;
				syncPipe[i+1] <= hdrPkg::syncIdle;
			end
			else
			begin
				remPipe[i+1] <= fits ? remPipe[i] - shifted : remPipe[i];
				divPipe[i+1] <= divPipe[i];
				quoPipe[i+1] <= {quoPipe[i][hdrPkg::chanWidth-2:0], fits};
				syncPipe[i+1] <= syncPipe[i];
			end
		end
	end

	assign quotient = quoPipe[hdrPkg::chanWidth];
	assign syncOut = syncPipe[hdrPkg::chanWidth];

endmodule

//--- src/pixelAlign.sv
`timescale 1ns/1ps

module pixelAlign
(
	input  logic clk,
	input  logic reset,
	input  hdrPkg::exposureSet_t exposures,
	input  hdrPkg::syncStrobes_t syncIn,
	output hdrPkg::exposureSet_t alignedExposures,
	output hdrPkg::syncStrobes_t alignedSync
);

	// one entry per cycle of the weight path
	hdrPkg::exposureSet_t [hdrPkg::weightLatency-1:0] expDly;
	hdrPkg::syncStrobes_t [hdrPkg::weightLatency-1:0] syncDly;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			expDly <= '0;
			syncDly <= {hdrPkg::weightLatency{hdrPkg::syncIdle}};
		end
		else
		begin
			expDly <= {expDly[hdrPkg::weightLatency-2:0], exposures};
			syncDly <= {syncDly[hdrPkg::weightLatency-2:0], syncIn};
		end
	end

	assign alignedExposures = expDly[hdrPkg::weightLatency-1];
	assign alignedSync = syncDly[hdrPkg::weightLatency-1];

endmodule

//--- weight/exposureWeight.sv
`timescale 1ns/1ps

module exposureWeight
(
	input  logic clk,
	input  logic reset,
	input  hdrPkg::pixel_t pixel,
	output logic [hdrPkg::weightWidth-1:0] weight
);

	logic [hdrPkg::chanWidth:0] rgSum;          // stage 1
	logic [hdrPkg::chanWidth-1:0] bDly;
	logic [hdrPkg::chanWidth+1:0] rgbSum;       // stage 2, at most 765
	logic [hdrPkg::chanWidth+hdrPkg::lumaShift-1:0] lumaProd;   // stage 3
	logic [hdrPkg::chanWidth-1:0] luma;         // stage 4
	logic [hdrPkg::chanWidth-1:0] lumaInv;
	logic [hdrPkg::chanWidth-1:0] lowSide;

	// ====================
	// luma
	// ====================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rgSum <= '0;
			bDly <= '0;
			rgbSum <= '0;
			lumaProd <= '0;
			luma <= '0;
		end
		else
		begin
			rgSum <= pixel.r + pixel.g;
			bDly <= pixel.b;
			rgbSum <= rgSum + bDly;
			lumaProd <= rgbSum * hdrPkg::lumaScale;
			// round on the highest dropped bit, 765 * 341 still lands on 255
			luma <= lumaProd[hdrPkg::chanWidth+hdrPkg::lumaShift-1:hdrPkg::lumaShift]
				+ hdrPkg::chanWidth'(lumaProd[hdrPkg::lumaShift-1]);
		end
	end

	// ====================
	// hat-shaped weight
	// ====================
	assign lumaInv = ~luma;   // 255 - luma
	assign lowSide = (luma < lumaInv) ? luma : lumaInv;

	// distance from the nearer rail, doubled, plus one so it is never zero
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			weight <= '0;
		else
			weight <= {lowSide[hdrPkg::chanWidth-2:0], 1'b1};   // lowSide <= 127
	end

endmodule

//--- common/hdrPkg.sv
package hdrPkg;

	// ====================
	// widths
	// ====================
	localparam int chanWidth = 8;
	localparam int weightWidth = 8;
	localparam int numWidth = 18;         // sum of four 8x8 products
	localparam int weightSumWidth = 10;   // sum of four weights

	// luma = (r + g + b) / 3, done as a multiply by 341/1024
	localparam logic [9:0] lumaScale = 10'd341;
	localparam int lumaShift = 10;

	// ====================
	// latencies
	// ====================
	localparam int weightLatency = 5;
	localparam int fusionLatency = 12;    // products, adder tree, divider, output
	localparam int totalLatency = weightLatency + fusionLatency;

	// ====================
	// bundles
	// ====================
	typedef struct packed {
		logic [chanWidth-1:0] r;
		logic [chanWidth-1:0] g;
		logic [chanWidth-1:0] b;
	} pixel_t;

	// one scene at four exposures, brightest first
	typedef struct packed {
		pixel_t bright;
		pixel_t midHigh;
		pixel_t midLow;
		pixel_t dark;
	} exposureSet_t;

	typedef struct packed {
		logic [weightWidth-1:0] bright;
		logic [weightWidth-1:0] midHigh;
		logic [weightWidth-1:0] midLow;
		logic [weightWidth-1:0] dark;
	} weightSet_t;

	typedef struct packed {
		logic vs;
		logic hs;
		logic de;
	} syncStrobes_t;

	// strobe value held in every delay stage during reset
	localparam syncStrobes_t syncIdle = '{vs: 1'b1, hs: 1'b1, de: 1'b0};

endpackage
